// File: rtl/wq_pkg.sv
// work queue manager shared types
`default_nettype none

package wq_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int NUM_QP      = 4;
  localparam int QPN_W       = 2;
  localparam int IDX_W       = 16;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int MTU_BYTES   = 256;
  localparam int WQE_WORDS   = 4;
  localparam int WQE_WIDX_W  = $clog2(WQE_WORDS);
  localparam int WQE_BYTES   = 16;
  localparam int CMPL_BYTES  = 4;

  ////////////////////
  // opcodes
  ////////////////////

  // opcode field of WQE word 0
  typedef enum logic [7:0] {
    WQE_WRITE = 8'h00,
    WQE_SEND  = 8'h02,
    WQE_READ  = 8'h04
  } wqe_op_e;

  // RC transport request opcodes
  typedef enum logic [7:0] {
    RC_SEND_FIRST   = 8'h00,
    RC_SEND_MIDDLE  = 8'h01,
    RC_SEND_LAST    = 8'h02,
    RC_SEND_ONLY    = 8'h04,
    RC_WRITE_FIRST  = 8'h06,
    RC_WRITE_MIDDLE = 8'h07,
    RC_WRITE_LAST   = 8'h08,
    RC_WRITE_ONLY   = 8'h0A,
    RC_READ_REQUEST = 8'h0C
  } rc_op_e;

  // WQE as read from memory, word 0 in the low bits
  typedef struct packed {
    logic [ADDR_W-1:0] raddr;
    logic [ADDR_W-1:0] laddr;
    logic [DATA_W-1:0] len;
    logic [15:0]       wr_id;
    logic [7:0]        rsvd;
    logic [7:0]        opcode;
  } wqe_t;

  ////////////////////
  // port structs
  ////////////////////

  typedef struct packed {
    logic [QPN_W-1:0]  qpn;
    logic [IDX_W-1:0]  prod_idx;
    logic [ADDR_W-1:0] sq_base;
    logic [ADDR_W-1:0] cq_base;
    logic              signal_cmpl;
  } doorbell_t;

  typedef struct packed {
    rc_op_e            opcode;
    logic [QPN_W-1:0]  qpn;
    logic              last;
    logic [ADDR_W-1:0] remote_addr;
    logic [ADDR_W-1:0] local_addr;
    logic [DATA_W-1:0] len;
  } sq_req_t;

  typedef struct packed {
    logic [15:0] wr_id;
    wqe_op_e     opcode;
  } cmpl_rec_t;

  typedef struct packed {
    logic [QPN_W-1:0] qpn;
    logic [IDX_W-1:0] head;
  } cq_head_t;

  typedef struct packed {
    logic [ADDR_W-1:0] sq_base;
    logic [ADDR_W-1:0] cq_base;
    logic [IDX_W-1:0]  fetch_idx;
    logic [IDX_W-1:0]  cq_head;
    logic              signal_cmpl;
    cmpl_rec_t         cmpl;
  } qp_ctx_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [ADDR_W-1:0]   adr;
    logic [DATA_W-1:0]   dat;
    logic [DATA_W/8-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/qp_context_table.sv
// per-QP context table
`timescale 1ns/1ps
`default_nettype none

module qp_context_table (
  input  wire                      axis_aclk_i,
  input  wire                      axis_rstn_i,

  input  wire                      db_valid_i,
  input  wq_pkg::doorbell_t        db_i,

  output logic                     pend_valid_o,
  output logic [wq_pkg::QPN_W-1:0] pend_qpn_o,
  output wq_pkg::qp_ctx_t          pend_ctx_o,

  input  wire                      fetch_done_i,
  input  wire  [wq_pkg::QPN_W-1:0] fetch_qpn_i,
  input  wire                      fetch_has_cmpl_i,
  input  wq_pkg::cmpl_rec_t        fetch_cmpl_i,

  input  wire  [wq_pkg::QPN_W-1:0] ack_qpn_i,
  output wq_pkg::qp_ctx_t          ack_ctx_o,
  input  wire                      cq_adv_i
);

  import wq_pkg::*;

  logic [IDX_W-1:0]  prod_idx_q  [NUM_QP];
  logic [IDX_W-1:0]  fetch_idx_q [NUM_QP];
  logic [IDX_W-1:0]  cq_head_q   [NUM_QP];
  logic              signal_q    [NUM_QP];
  logic [ADDR_W-1:0] sq_base_q   [NUM_QP];
  logic [ADDR_W-1:0] cq_base_q   [NUM_QP];
  cmpl_rec_t         cmpl_q      [NUM_QP];

  qp_ctx_t           ctx         [NUM_QP];

  ////////////////////
  // indices
  ////////////////////

  // the three update sources own separate fields
  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      for (int q = 0; q < NUM_QP; q++) begin
        prod_idx_q[q]  <= '0;
        fetch_idx_q[q] <= '0;
        cq_head_q[q]   <= '0;
        signal_q[q]    <= 1'b0;
      end
    end else begin
      if (db_valid_i) begin
        prod_idx_q[db_i.qpn] <= db_i.prod_idx;
        signal_q[db_i.qpn]   <= db_i.signal_cmpl;
      end
      if (fetch_done_i) begin
        fetch_idx_q[fetch_qpn_i] <= fetch_idx_q[fetch_qpn_i] + IDX_W'(1);
      end
      if (cq_adv_i) begin
        cq_head_q[ack_qpn_i] <= cq_head_q[ack_qpn_i] + IDX_W'(1);
      end
    end
  end

  // base addresses and the last completion record
  always_ff @(posedge axis_aclk_i) begin
    if (db_valid_i) begin
      sq_base_q[db_i.qpn] <= db_i.sq_base;
      cq_base_q[db_i.qpn] <= db_i.cq_base;
    end
    if (fetch_done_i && fetch_has_cmpl_i) begin
      cmpl_q[fetch_qpn_i] <= fetch_cmpl_i;
    end
  end

  ////////////////////
  // read side
  ////////////////////

  always_comb begin
    for (int q = 0; q < NUM_QP; q++) begin
      ctx[q].sq_base     = sq_base_q[q];
      ctx[q].cq_base     = cq_base_q[q];
      ctx[q].fetch_idx   = fetch_idx_q[q];
      ctx[q].cq_head     = cq_head_q[q];
      ctx[q].signal_cmpl = signal_q[q];
      ctx[q].cmpl        = cmpl_q[q];
    end
  end

  // scan downwards so the lowest pending QP wins
  always_comb begin
    pend_valid_o = 1'b0;
    pend_qpn_o   = '0;
    for (int q = NUM_QP - 1; q >= 0; q--) begin
      if (fetch_idx_q[q] != prod_idx_q[q]) begin
        pend_valid_o = 1'b1;
        pend_qpn_o   = QPN_W'(q);
      end
    end
  end

  assign pend_ctx_o = ctx[pend_qpn_o];
  assign ack_ctx_o  = ctx[ack_qpn_i];

endmodule

`default_nettype wire

// File: rtl/wqe_fetch_segmenter.sv
// WQE fetch and segmentation engine
`timescale 1ns/1ps
`default_nettype none

module wqe_fetch_segmenter (
  input  wire                      axis_aclk_i,
  input  wire                      axis_rstn_i,

  input  wire                      pend_valid_i,
  input  wire  [wq_pkg::QPN_W-1:0] pend_qpn_i,
  input  wq_pkg::qp_ctx_t          pend_ctx_i,

  output logic                     fetch_done_o,
  output logic [wq_pkg::QPN_W-1:0] fetch_qpn_o,
  output logic                     fetch_has_cmpl_o,
  output wq_pkg::cmpl_rec_t        fetch_cmpl_o,

  output wq_pkg::wb_req_t          wb_req_o,
  input  wq_pkg::wb_rsp_t          wb_rsp_i,

  output logic                     sq_req_valid_o,
  input  wire                      sq_req_ready_i,
  output wq_pkg::sq_req_t          sq_req_o
);

  import wq_pkg::*;

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_READ,
    FS_DECODE,
    FS_SEG,
    FS_DONE
  } fs_state_e;

  fs_state_e state_q, state_d;

  logic [QPN_W-1:0]                  qpn_q;
  logic [ADDR_W-1:0]                 base_q;
  logic [WQE_WIDX_W-1:0]             word_q;
  logic [WQE_WORDS-1:0][DATA_W-1:0]  wqe_words_q;
  logic [DATA_W-1:0]                 rem_q;
  logic [ADDR_W-1:0]                 laddr_q;
  logic [ADDR_W-1:0]                 raddr_q;
  logic                              first_q;

  wqe_t   wqe;
  logic   known_op;
  logic   is_read;
  logic   is_send;
  logic   seg_last;
  logic   seg_xfer;
  rc_op_e seg_op;

  assign wqe      = wqe_t'(wqe_words_q);
  assign known_op = wqe.opcode inside {WQE_WRITE, WQE_SEND, WQE_READ};
  assign is_read  = (wqe.opcode == WQE_READ);
  assign is_send  = (wqe.opcode == WQE_SEND);
  // a read request always goes out whole
  assign seg_last = is_read || (rem_q <= DATA_W'(MTU_BYTES));
  assign seg_xfer = sq_req_valid_o && sq_req_ready_i;

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (pend_valid_i) begin
          state_d = FS_READ;
        end
      end
      FS_READ: begin
        if (wb_rsp_i.ack && word_q == WQE_WIDX_W'(WQE_WORDS - 1)) begin
          state_d = FS_DECODE;
        end
      end
      // unknown opcodes skip straight to done
      FS_DECODE: state_d = known_op ? FS_SEG : FS_DONE;
      FS_SEG: begin
        if (seg_xfer && seg_last) begin
          state_d = FS_DONE;
        end
      end
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= FS_IDLE;
      word_q  <= '0;
      first_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == FS_IDLE) begin
        word_q <= '0;
      end else if (state_q == FS_READ && wb_rsp_i.ack) begin
        word_q <= word_q + WQE_WIDX_W'(1);
      end
      if (state_q == FS_DECODE) begin
        first_q <= 1'b1;
      end else if (state_q == FS_SEG && seg_xfer) begin
        first_q <= 1'b0;
      end
    end
  end

  // WQE words and segment counters
  always_ff @(posedge axis_aclk_i) begin
    if (state_q == FS_IDLE && pend_valid_i) begin
      qpn_q  <= pend_qpn_i;
      base_q <= pend_ctx_i.sq_base + ADDR_W'(pend_ctx_i.fetch_idx) * ADDR_W'(WQE_BYTES);
    end
    if (state_q == FS_READ && wb_rsp_i.ack) begin
      wqe_words_q[word_q] <= wb_rsp_i.dat;
    end
    if (state_q == FS_DECODE) begin
      rem_q   <= wqe.len;
      laddr_q <= wqe.laddr;
      raddr_q <= wqe.raddr;
    end else if (state_q == FS_SEG && seg_xfer) begin
      rem_q   <= rem_q - DATA_W'(MTU_BYTES);
      laddr_q <= laddr_q + ADDR_W'(MTU_BYTES);
      raddr_q <= raddr_q + ADDR_W'(MTU_BYTES);
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  always_comb begin
    seg_op = RC_READ_REQUEST;
    if (is_send) begin
      if (first_q && seg_last) begin
        seg_op = RC_SEND_ONLY;
      end else if (first_q) begin
        seg_op = RC_SEND_FIRST;
      end else if (seg_last) begin
        seg_op = RC_SEND_LAST;
      end else begin
        seg_op = RC_SEND_MIDDLE;
      end
    end else if (!is_read) begin
      if (first_q && seg_last) begin
        seg_op = RC_WRITE_ONLY;
      end else if (first_q) begin
        seg_op = RC_WRITE_FIRST;
      end else if (seg_last) begin
        seg_op = RC_WRITE_LAST;
      end else begin
        seg_op = RC_WRITE_MIDDLE;
      end
    end
  end

  assign sq_req_valid_o       = (state_q == FS_SEG);
  assign sq_req_o.opcode      = seg_op;
  assign sq_req_o.qpn         = qpn_q;
  assign sq_req_o.last        = seg_last;
  // send carries no remote address
  assign sq_req_o.remote_addr = is_send ? '0 : raddr_q;
  assign sq_req_o.local_addr  = laddr_q;
  assign sq_req_o.len         = seg_last ? rem_q : DATA_W'(MTU_BYTES);

  assign wb_req_o.cyc = (state_q == FS_READ);
  assign wb_req_o.stb = (state_q == FS_READ);
  assign wb_req_o.we  = 1'b0;
  assign wb_req_o.adr = base_q + ADDR_W'({word_q, 2'b00});
  assign wb_req_o.dat = '0;
  assign wb_req_o.sel = '1;

  assign fetch_done_o        = (state_q == FS_DONE);
  assign fetch_qpn_o         = qpn_q;
  assign fetch_has_cmpl_o    = known_op;
  assign fetch_cmpl_o.wr_id  = wqe.wr_id;
  assign fetch_cmpl_o.opcode = wqe_op_e'(wqe.opcode);

endmodule

`default_nettype wire

// File: rtl/cq_completion_writer.sv
// CQ completion writer
`timescale 1ns/1ps
`default_nettype none

module cq_completion_writer (
  input  wire                      axis_aclk_i,
  input  wire                      axis_rstn_i,

  input  wire                      ack_valid_i,
  input  wire  [wq_pkg::QPN_W-1:0] ack_qpn_i,
  output logic                     ack_ready_o,

  output logic [wq_pkg::QPN_W-1:0] ctx_qpn_o,
  input  wq_pkg::qp_ctx_t          ctx_i,
  output logic                     cq_adv_o,

  output wq_pkg::wb_req_t          wb_req_o,
  input  wq_pkg::wb_rsp_t          wb_rsp_i,

  output logic                     cq_head_valid_o,
  output wq_pkg::cq_head_t         cq_head_o
);

  import wq_pkg::*;

  typedef enum logic [1:0] {
    CW_IDLE,
    CW_CTX,
    CW_WRITE,
    CW_REPORT
  } cw_state_e;

  cw_state_e state_q, state_d;

  logic [QPN_W-1:0]  qpn_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] word_q;
  logic [IDX_W-1:0]  head_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CW_IDLE: begin
        if (ack_valid_i) begin
          state_d = CW_CTX;
        end
      end
      // unsignalled QPs skip the memory write
      CW_CTX: state_d = ctx_i.signal_cmpl ? CW_WRITE : CW_REPORT;
      CW_WRITE: begin
        if (wb_rsp_i.ack) begin
          state_d = CW_REPORT;
        end
      end
      default: state_d = CW_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= CW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (state_q == CW_IDLE && ack_valid_i) begin
      qpn_q <= ack_qpn_i;
    end
    if (state_q == CW_CTX) begin
      addr_q <= ctx_i.cq_base + ADDR_W'(ctx_i.cq_head) * ADDR_W'(CMPL_BYTES);
      // status byte stays zero
      word_q <= {8'h00, ctx_i.cmpl.opcode, ctx_i.cmpl.wr_id};
      head_q <= ctx_i.cq_head + IDX_W'(1);
    end
  end

  assign ack_ready_o = (state_q == CW_IDLE);
  assign ctx_qpn_o   = qpn_q;
  assign cq_adv_o    = (state_q == CW_REPORT);

  assign cq_head_valid_o = (state_q == CW_REPORT);
  assign cq_head_o.qpn   = qpn_q;
  assign cq_head_o.head  = head_q;

  assign wb_req_o.cyc = (state_q == CW_WRITE);
  assign wb_req_o.stb = (state_q == CW_WRITE);
  assign wb_req_o.we  = 1'b1;
  assign wb_req_o.adr = addr_q;
  assign wb_req_o.dat = word_q;
  assign wb_req_o.sel = '1;

endmodule

`default_nettype wire

// File: rtl/wb_master_arbiter.sv
// two master Wishbone arbiter
`timescale 1ns/1ps
`default_nettype none

module wb_master_arbiter (
  input  wire             axis_aclk_i,
  input  wire             axis_rstn_i,

  input  wq_pkg::wb_req_t m0_req_i,
  output wq_pkg::wb_rsp_t m0_rsp_o,
  input  wq_pkg::wb_req_t m1_req_i,
  output wq_pkg::wb_rsp_t m1_rsp_o,

  output wq_pkg::wb_req_t wb_o,
  input  wq_pkg::wb_rsp_t wb_i
);

  logic busy_q;
  logic owner_q;
  logic sel;
  logic owner_cyc;

  // m0 wins whenever the bus is free
  assign sel       = busy_q ? owner_q : ~m0_req_i.cyc;
  assign owner_cyc = owner_q ? m1_req_i.cyc : m0_req_i.cyc;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (!busy_q) begin
      if (m0_req_i.cyc || m1_req_i.cyc) begin
        busy_q  <= 1'b1;
        owner_q <= sel;
      end
    end else if (!owner_cyc) begin
      busy_q <= 1'b0;
    end
  end

  assign wb_o = sel ? m1_req_i : m0_req_i;

  // ack only to the current owner
  assign m0_rsp_o.ack = wb_i.ack & ~sel;
  assign m0_rsp_o.dat = wb_i.dat;
  assign m1_rsp_o.ack = wb_i.ack & sel;
  assign m1_rsp_o.dat = wb_i.dat;

endmodule

`default_nettype wire

// File: rtl/wq_manager_top.sv
// send queue work queue manager
`timescale 1ns/1ps
`default_nettype none

module wq_manager_top (
  input  wire                      axis_aclk_i,
  input  wire                      axis_rstn_i,

  input  wire                      db_valid_i,
  input  wq_pkg::doorbell_t        db_i,

  output logic                     sq_req_valid_o,
  input  wire                      sq_req_ready_i,
  output wq_pkg::sq_req_t          sq_req_o,

  input  wire                      ack_valid_i,
  input  wire  [wq_pkg::QPN_W-1:0] ack_qpn_i,
  output logic                     ack_ready_o,

  output logic                     cq_head_valid_o,
  output wq_pkg::cq_head_t         cq_head_o,

  output wq_pkg::wb_req_t          wb_o,
  input  wq_pkg::wb_rsp_t          wb_i
);

  import wq_pkg::*;

  logic             pend_valid;
  logic [QPN_W-1:0] pend_qpn;
  qp_ctx_t          pend_ctx;

  logic             fetch_done;
  logic [QPN_W-1:0] fetch_qpn;
  logic             fetch_has_cmpl;
  cmpl_rec_t        fetch_cmpl;

  logic [QPN_W-1:0] ack_qpn;
  qp_ctx_t          ack_ctx;
  logic             cq_adv;

  wb_req_t          fetch_wb_req;
  wb_rsp_t          fetch_wb_rsp;
  wb_req_t          cmpl_wb_req;
  wb_rsp_t          cmpl_wb_rsp;

  ////////////////////
  // context table
  ////////////////////

  qp_context_table u_qp_context_table (
    .axis_aclk_i      (axis_aclk_i),
    .axis_rstn_i      (axis_rstn_i),
    .db_valid_i       (db_valid_i),
    .db_i             (db_i),
    .pend_valid_o     (pend_valid),
    .pend_qpn_o       (pend_qpn),
    .pend_ctx_o       (pend_ctx),
    .fetch_done_i     (fetch_done),
    .fetch_qpn_i      (fetch_qpn),
    .fetch_has_cmpl_i (fetch_has_cmpl),
    .fetch_cmpl_i     (fetch_cmpl),
    .ack_qpn_i        (ack_qpn),
    .ack_ctx_o        (ack_ctx),
    .cq_adv_i         (cq_adv)
  );

  ////////////////////
  // engines
  ////////////////////

  wqe_fetch_segmenter u_wqe_fetch_segmenter (
    .axis_aclk_i      (axis_aclk_i),
    .axis_rstn_i      (axis_rstn_i),
    .pend_valid_i     (pend_valid),
    .pend_qpn_i       (pend_qpn),
    .pend_ctx_i       (pend_ctx),
    .fetch_done_o     (fetch_done),
    .fetch_qpn_o      (fetch_qpn),
    .fetch_has_cmpl_o (fetch_has_cmpl),
    .fetch_cmpl_o     (fetch_cmpl),
    .wb_req_o         (fetch_wb_req),
    .wb_rsp_i         (fetch_wb_rsp),
    .sq_req_valid_o   (sq_req_valid_o),
    .sq_req_ready_i   (sq_req_ready_i),
    .sq_req_o         (sq_req_o)
  );

  cq_completion_writer u_cq_completion_writer (
    .axis_aclk_i     (axis_aclk_i),
    .axis_rstn_i     (axis_rstn_i),
    .ack_valid_i     (ack_valid_i),
    .ack_qpn_i       (ack_qpn_i),
    .ack_ready_o     (ack_ready_o),
    .ctx_qpn_o       (ack_qpn),
    .ctx_i           (ack_ctx),
    .cq_adv_o        (cq_adv),
    .wb_req_o        (cmpl_wb_req),
    .wb_rsp_i        (cmpl_wb_rsp),
    .cq_head_valid_o (cq_head_valid_o),
    .cq_head_o       (cq_head_o)
  );

  // completion writer is m0 and gets priority
  wb_master_arbiter u_wb_master_arbiter (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .m0_req_i    (cmpl_wb_req),
    .m0_rsp_o    (cmpl_wb_rsp),
    .m1_req_i    (fetch_wb_req),
    .m1_rsp_o    (fetch_wb_rsp),
    .wb_o        (wb_o),
    .wb_i        (wb_i)
  );

endmodule

`default_nettype wire

// File: verif/wb_mem_model.sv
// Wishbone memory model
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
  input  wire             axis_aclk_i,
  input  wire             axis_rstn_i,
  input  wq_pkg::wb_req_t wb_i,
  output wq_pkg::wb_rsp_t wb_o
);

  localparam int WORDS   = 1024;
  localparam int LOG_MAX = 64;

  logic [31:0] mem      [WORDS];
  logic [31:0] log_addr [LOG_MAX];
  logic [31:0] log_data [LOG_MAX];
  int          log_cnt;

  // every address gets its own pattern
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    fill_word = {adr[15:0], adr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    if (adr < WORDS * 4) begin
      read_word = mem[adr[11:2]];
    end else begin
      read_word = fill_word(adr);
    end
  endfunction

  task automatic load_word(input logic [31:0] adr, input logic [31:0] data);
    mem[adr[11:2]] = data;
  endtask

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = fill_word(32'(i * 4));
    end
  end

  // ack one cycle after stb, then drop for a cycle
  always @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      wb_o.ack <= 1'b0;
      wb_o.dat <= '0;
      log_cnt  <= 0;
    end else if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
      wb_o.ack <= 1'b1;
      wb_o.dat <= read_word(wb_i.adr);
      if (wb_i.we) begin
        if (wb_i.adr < WORDS * 4) begin
          mem[wb_i.adr[11:2]] <= wb_i.dat;
        end
        if (log_cnt < LOG_MAX) begin
          log_addr[log_cnt] <= wb_i.adr;
          log_data[log_cnt] <= wb_i.dat;
        end
        log_cnt <= log_cnt + 1;
      end
    end else begin
      wb_o.ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verif/wq_manager_tb.sv
// work queue manager testbench
`timescale 1ns/1ps
`default_nettype none

module wq_manager_tb;

  import wq_pkg::*;

  localparam int TIMEOUT = 2000;

  logic             axis_aclk;
  logic             axis_rstn;
  logic             db_valid;
  doorbell_t        db;
  logic             sq_req_valid;
  logic             sq_req_ready;
  sq_req_t          sq_req;
  logic             ack_valid;
  logic [QPN_W-1:0] ack_qpn;
  logic             ack_ready;
  logic             cq_head_valid;
  cq_head_t         cq_head;
  wb_req_t          wb_req;
  wb_rsp_t          wb_rsp;

  integer           seed = 32'hd259_6779;
  logic [31:0]      rand_bits;
  logic             rand_ready;

  // reference state per QP
  logic [IDX_W-1:0] prod_m  [NUM_QP];
  logic [IDX_W-1:0] head_m  [NUM_QP];
  logic [7:0]       last_op [NUM_QP];
  logic [15:0]      last_id [NUM_QP];
  logic             signal_m [NUM_QP];

  sq_req_t          exp_q [$];
  sq_req_t          exp_r;
  int               err_cnt;
  int               check_cnt;
  int               test_no;
  int               err_start;

  wq_manager_top u_wq_manager_top (
    .axis_aclk_i     (axis_aclk),
    .axis_rstn_i     (axis_rstn),
    .db_valid_i      (db_valid),
    .db_i            (db),
    .sq_req_valid_o  (sq_req_valid),
    .sq_req_ready_i  (sq_req_ready),
    .sq_req_o        (sq_req),
    .ack_valid_i     (ack_valid),
    .ack_qpn_i       (ack_qpn),
    .ack_ready_o     (ack_ready),
    .cq_head_valid_o (cq_head_valid),
    .cq_head_o       (cq_head),
    .wb_o            (wb_req),
    .wb_i            (wb_rsp)
  );

  wb_mem_model u_mem (
    .axis_aclk_i (axis_aclk),
    .axis_rstn_i (axis_rstn),
    .wb_i        (wb_req),
    .wb_o        (wb_rsp)
  );

  always #4 axis_aclk = ~axis_aclk;

  always @(posedge axis_aclk) begin
    #1;
    if (rand_ready) begin
      rand_bits    = $random(seed);
      sq_req_ready = rand_bits[0];
    end else begin
      sq_req_ready = 1'b1;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] sq_base_of(input int q);
    sq_base_of = 32'h200 * q;
  endfunction

  function automatic logic [31:0] cq_base_of(input int q);
    cq_base_of = 32'h800 + 32'h100 * q;
  endfunction

  // one WQE into its list of transport requests
  function automatic void expand_wqe(input logic [1:0] qpn, input logic [7:0] op,
                                     input logic [31:0] len, input logic [31:0] laddr,
                                     input logic [31:0] raddr);
    sq_req_t r;
    int      nseg;
    int      i;
    logic    first;
    r.qpn = qpn;
    if (op == WQE_READ) begin
      r.opcode      = RC_READ_REQUEST;
      r.last        = 1'b1;
      r.remote_addr = raddr;
      r.local_addr  = laddr;
      r.len         = len;
      exp_q.push_back(r);
    end else if (op == WQE_WRITE || op == WQE_SEND) begin
      nseg = (len + MTU_BYTES - 1) / MTU_BYTES;
      if (nseg == 0) begin
        nseg = 1;
      end
      for (i = 0; i < nseg; i++) begin
        first         = (i == 0);
        r.last        = (i == nseg - 1);
        r.len         = r.last ? len - 32'(i * MTU_BYTES) : 32'(MTU_BYTES);
        r.local_addr  = laddr + 32'(i * MTU_BYTES);
        r.remote_addr = (op == WQE_SEND) ? 32'h0 : raddr + 32'(i * MTU_BYTES);
        if (op == WQE_SEND) begin
          if (first && r.last) r.opcode = RC_SEND_ONLY;
          else if (first)      r.opcode = RC_SEND_FIRST;
          else if (r.last)     r.opcode = RC_SEND_LAST;
          else                 r.opcode = RC_SEND_MIDDLE;
        end else begin
          if (first && r.last) r.opcode = RC_WRITE_ONLY;
          else if (first)      r.opcode = RC_WRITE_FIRST;
          else if (r.last)     r.opcode = RC_WRITE_LAST;
          else                 r.opcode = RC_WRITE_MIDDLE;
        end
        exp_q.push_back(r);
      end
    end
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    check_cnt++;
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("tests failed");
    $finish;
  endtask

  // a transfer happens at the next rising edge
  always @(negedge axis_aclk) begin
    if (axis_rstn && sq_req_valid && sq_req_ready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected transport request on QP %0d", sq_req.qpn);
      end else begin
        exp_r = exp_q.pop_front();
        check_value("sq_req_o.opcode", exp_r.opcode, sq_req.opcode);
        check_value("sq_req_o.qpn", exp_r.qpn, sq_req.qpn);
        check_value("sq_req_o.last", exp_r.last, sq_req.last);
        check_value("sq_req_o.remote_addr", exp_r.remote_addr, sq_req.remote_addr);
        check_value("sq_req_o.local_addr", exp_r.local_addr, sq_req.local_addr);
        check_value("sq_req_o.len", exp_r.len, sq_req.len);
      end
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic post_wqe(input logic [1:0] q, input logic [7:0] op, input logic [15:0] wr_id,
                          input logic [31:0] len, input logic [31:0] laddr,
                          input logic [31:0] raddr);
    logic [31:0] adr;
    adr = sq_base_of(q) + 32'(prod_m[q]) * WQE_BYTES;
    u_mem.load_word(adr, {wr_id, 8'h00, op});
    u_mem.load_word(adr + 4, len);
    u_mem.load_word(adr + 8, laddr);
    u_mem.load_word(adr + 12, raddr);
    expand_wqe(q, op, len, laddr, raddr);
    if (op == WQE_WRITE || op == WQE_SEND || op == WQE_READ) begin
      last_op[q] = op;
      last_id[q] = wr_id;
    end
    prod_m[q] = prod_m[q] + 1'b1;
  endtask

  task automatic ring_doorbell(input logic [1:0] q);
    db.qpn         = q;
    db.prod_idx    = prod_m[q];
    db.sq_base     = sq_base_of(q);
    db.cq_base     = cq_base_of(q);
    db.signal_cmpl = signal_m[q];
    db_valid       = 1'b1;
    @(posedge axis_aclk);
    #1;
    db_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge axis_aclk);
      #1;
      n++;
      if (n > TIMEOUT) abort_run("expected transport requests never arrived");
    end
  endtask

  task automatic ack_and_check(input logic [1:0] q);
    int          n;
    int          log_start;
    logic [31:0] exp_addr;
    logic [31:0] exp_word;
    exp_addr  = cq_base_of(q) + 32'(head_m[q]) * CMPL_BYTES;
    exp_word  = {8'h00, last_op[q], last_id[q]};
    log_start = u_mem.log_cnt;
    n = 0;
    while (!ack_ready) begin
      @(posedge axis_aclk);
      #1;
      n++;
      if (n > TIMEOUT) abort_run("ack_ready_o stayed low");
    end
    ack_valid = 1'b1;
    ack_qpn   = q;
    @(posedge axis_aclk);
    #1;
    ack_valid = 1'b0;
    // writer is busy once the ack is taken
    check_value("ack_ready_o", 0, ack_ready);
    // counted from the transfer edge
    n = 1;
    while (!cq_head_valid) begin
      @(posedge axis_aclk);
      #1;
      n++;
      if (n > TIMEOUT) abort_run("no CQ head report after the ack");
    end
    check_value("cq_head_o.qpn", q, cq_head.qpn);
    check_value("cq_head_o.head", head_m[q] + 1'b1, cq_head.head);
    if (signal_m[q]) begin
      check_value("completion write count", log_start + 1, u_mem.log_cnt);
      if (u_mem.log_cnt > log_start) begin
        check_value("completion address", exp_addr, u_mem.log_addr[log_start]);
        check_value("completion word", exp_word, u_mem.log_data[log_start]);
      end
    end else begin
      check_value("completion write count", log_start, u_mem.log_cnt);
      check_value("cq_head_valid_o latency", 2, n);
    end
    head_m[q] = head_m[q] + 1'b1;
    @(posedge axis_aclk);
    #1;
    check_value("cq_head_valid_o", 0, cq_head_valid);
  endtask

  task automatic start_test();
    test_no++;
    err_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s: %s", test_no, name, (err_cnt == err_start) ? "ok" : "errors");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    axis_aclk    = 1'b0;
    axis_rstn    = 1'b0;
    db_valid     = 1'b0;
    db           = '0;
    ack_valid    = 1'b0;
    ack_qpn      = '0;
    sq_req_ready = 1'b1;
    rand_ready   = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    test_no      = 0;
    for (int q = 0; q < NUM_QP; q++) begin
      prod_m[q]   = '0;
      head_m[q]   = '0;
      last_op[q]  = '0;
      last_id[q]  = '0;
      signal_m[q] = (q != 3);
    end
    repeat (5) @(posedge axis_aclk);
    #1;
    axis_rstn = 1'b1;

    start_test();
    post_wqe(0, WQE_WRITE, 16'h0101, 32'd200, 32'h1000_0000, 32'h8000_0000);
    post_wqe(0, WQE_WRITE, 16'h0102, 32'd256, 32'h1000_1000, 32'h8000_2000);
    ring_doorbell(0);
    wait_drain();
    finish_test("write only");

    start_test();
    post_wqe(0, WQE_WRITE, 16'h0103, 32'd896, 32'h2000_0000, 32'h9000_0000);
    ring_doorbell(0);
    wait_drain();
    finish_test("segmented write");

    start_test();
    post_wqe(0, WQE_SEND, 16'h0104, 32'd600, 32'h3000_0000, 32'hdead_0000);
    post_wqe(0, WQE_READ, 16'h0105, 32'd1000, 32'h4000_0000, 32'ha000_0000);
    ring_doorbell(0);
    wait_drain();
    finish_test("send and read");

    // QP 0 keeps the fetcher busy while QP 2 and QP 1 ring
    start_test();
    rand_ready = 1'b1;
    post_wqe(0, WQE_WRITE, 16'h0106, 32'd1024, 32'h5000_0000, 32'hb000_0000);
    ring_doorbell(0);
    post_wqe(1, WQE_SEND, 16'h1101, 32'd520, 32'h5100_0000, 32'h0);
    post_wqe(1, WQE_WRITE, 16'h1102, 32'd100, 32'h5100_4000, 32'hb100_0000);
    post_wqe(2, WQE_READ, 16'h2101, 32'd4096, 32'h5200_0000, 32'hb200_0000);
    post_wqe(2, WQE_WRITE, 16'h2102, 32'd300, 32'h5200_4000, 32'hb200_4000);
    ring_doorbell(2);
    ring_doorbell(1);
    wait_drain();
    rand_ready = 1'b0;
    finish_test("random ready and QP order");

    // second ack on QP 0 sees the advanced head
    start_test();
    ack_and_check(0);
    ack_and_check(2);
    ack_and_check(0);
    finish_test("signalled ack");

    start_test();
    post_wqe(3, 8'h55, 16'h3101, 32'd64, 32'h6000_0000, 32'hc000_0000);
    post_wqe(3, WQE_WRITE, 16'h3102, 32'd300, 32'h6000_1000, 32'hc000_1000);
    ring_doorbell(3);
    wait_drain();
    ack_and_check(3);
    // a skipped WQE leaves the older completion record in place
    post_wqe(1, 8'hff, 16'h1103, 32'd16, 32'h6100_0000, 32'hc100_0000);
    post_wqe(2, WQE_WRITE, 16'h2103, 32'd64, 32'h6200_0000, 32'hc200_0000);
    ring_doorbell(1);
    ring_doorbell(2);
    wait_drain();
    ack_and_check(1);
    finish_test("unsignalled ack and skipped opcode");

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected transport requests still outstanding", exp_q.size());
    end
    $display("tests run: %0d, checks: %0d, errors: %0d", test_no, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wq_manager.f
rtl/wq_pkg.sv
rtl/qp_context_table.sv
rtl/wqe_fetch_segmenter.sv
rtl/cq_completion_writer.sv
rtl/wb_master_arbiter.sv
rtl/wq_manager_top.sv
verif/wb_mem_model.sv
verif/wq_manager_tb.sv
